//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // fetch datapath widths
  localparam int ADDR_W = 32;
  localparam int XLEN   = 32;

  // l1 instruction cache geometry, direct mapped
  localparam int L1I_SETS       = 8;
  localparam int L1I_IDX_W      = 3;
  localparam int L1I_LINE_WORDS = 2;
  localparam int L1I_OFS_W      = 1;

  // whatever is left above index, word offset and the two byte bits
  localparam int L1I_TAG_W = ADDR_W - L1I_IDX_W - L1I_OFS_W - 2;

  // first fetch address out of reset
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

  // fence.i, the only encoding the cache reacts to
  localparam logic [XLEN-1:0] FENCE_I_INST = 32'h0000_100f;

  // fetch queue sizing
  localparam int FQ_DEPTH = 4;
  localparam int FQ_PTR_W = 2;

endpackage

`default_nettype wire

//--- source/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         redirect_valid_i,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
  input  logic                         advance_i,
  output logic [fetch_pkg::ADDR_W-1:0] pc_o
);
  import fetch_pkg::*;

  // current fetch address, presented to the cache every cycle
  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_next;

  // sequential successor, no compressed instructions
  assign pc_next = pc_q + ADDR_W'(4);

  // redirect wins over a same-cycle advance
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC;
    end
    else if (redirect_valid_i)
    begin
      pc_q <= redirect_pc_i;
    end
    else if (advance_i)
    begin
      pc_q <= pc_next;
    end
  end

  // pc only moves after the cache handed the word to the queue,
  // so a stalled queue or a pending refill simply holds it here
  assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- source/l1i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1i_cache (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [fetch_pkg::ADDR_W-1:0] pc_i,
  input  logic                         flush_i,
  output logic                         hit_valid_o,
  output logic [fetch_pkg::XLEN-1:0]   inst_o,
  input  logic                         take_i,
  output logic                         fetched_o,
  output logic                         mem_arvalid_o,
  output logic [fetch_pkg::ADDR_W-1:0] mem_araddr_o,
  input  logic                         mem_arready_i,
  input  logic                         mem_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]   mem_rdata_i
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_BEAT0,
    ST_BEAT1
  } refill_state_e;

  // line storage
  logic [XLEN-1:0]      data_q [L1I_SETS][L1I_LINE_WORDS];
  logic [L1I_TAG_W-1:0] tag_q [L1I_SETS];
  logic [L1I_SETS-1:0]  valid_q;

  // refill bookkeeping
  refill_state_e        state_q;
  logic [L1I_TAG_W-1:0] ref_tag_q;
  logic [L1I_IDX_W-1:0] ref_idx_q;

  // lookup fields of the current pc
  logic [L1I_TAG_W-1:0] pc_tag;
  logic [L1I_IDX_W-1:0] pc_idx;
  logic [L1I_OFS_W-1:0] pc_ofs;
  logic                 hit;
  logic                 miss_req;
  logic                 fence_seen;

  assign pc_tag = pc_i[ADDR_W-1 -: L1I_TAG_W];
  assign pc_idx = pc_i[2+L1I_OFS_W +: L1I_IDX_W];
  assign pc_ofs = pc_i[2 +: L1I_OFS_W];

  assign hit         = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign hit_valid_o = hit;
  assign inst_o      = data_q[pc_idx][pc_ofs];

  // a redirect in this cycle means the pc is stale, so nothing is taken
  assign fetched_o  = hit && take_i && !flush_i;
  assign fence_seen = fetched_o && (inst_o == FENCE_I_INST);

  // only one refill at a time, new misses wait for idle
  assign miss_req = (state_q == ST_IDLE) && !hit;

  assign mem_arvalid_o = miss_req || (state_q == ST_REQ);

  // line aligned, from the live pc on the first cycle and the latch after
  assign mem_araddr_o = (state_q == ST_IDLE) ?
                        {pc_tag, pc_idx, {(L1I_OFS_W + 2){1'b0}}} :
                        {ref_tag_q, ref_idx_q, {(L1I_OFS_W + 2){1'b0}}};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= ST_IDLE;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (miss_req)
          begin
            state_q <= mem_arready_i ? ST_BEAT0 : ST_REQ;
          end
        end
        ST_REQ:
        begin
          if (mem_arready_i)
          begin
            state_q <= ST_BEAT0;
          end
        end
        ST_BEAT0:
        begin
          if (mem_rvalid_i)
          begin
            state_q <= ST_BEAT1;
          end
        end
        ST_BEAT1:
        begin
          if (mem_rvalid_i)
          begin
            state_q <= ST_IDLE;
          end
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // target line is fixed at the request, later pc changes do not matter
  always_ff @(posedge clk)
  begin
    if (miss_req)
    begin
      ref_tag_q <= pc_tag;
      ref_idx_q <= pc_idx;
    end
  end

  // beats arrive lowest word first
  always_ff @(posedge clk)
  begin
    if (state_q == ST_BEAT0 && mem_rvalid_i)
    begin
      data_q[ref_idx_q][0] <= mem_rdata_i;
    end
    if (state_q == ST_BEAT1 && mem_rvalid_i)
    begin
      data_q[ref_idx_q][1] <= mem_rdata_i;
      tag_q[ref_idx_q]     <= ref_tag_q;
    end
  end

  // fence.i clears everything, including a line finishing on the same edge.
  // the victim line is dropped at request time, as its words get overwritten
  // while other sets keep hitting
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (fence_seen)
    begin
      valid_q <= '0;
    end
    else
    begin
      if (miss_req)
      begin
        valid_q[pc_idx] <= 1'b0;
      end
      if (state_q == ST_BEAT1 && mem_rvalid_i)
      begin
        valid_q[ref_idx_q] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         flush_i,
  input  logic                         push_i,
  input  logic [fetch_pkg::ADDR_W-1:0] push_pc_i,
  input  logic [fetch_pkg::XLEN-1:0]   push_inst_i,
  output logic                         ready_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic [fetch_pkg::ADDR_W-1:0] out_pc_o,
  output logic [fetch_pkg::XLEN-1:0]   out_inst_o
);
  import fetch_pkg::*;

  // pc/instruction pairs
  logic [ADDR_W-1:0] pc_mem_q [FQ_DEPTH];
  logic [XLEN-1:0]   inst_mem_q [FQ_DEPTH];

  logic [FQ_PTR_W-1:0] wr_ptr_q;
  logic [FQ_PTR_W-1:0] rd_ptr_q;
  logic [FQ_PTR_W:0]   count_q;

  logic push;
  logic pop;

  assign ready_o     = (count_q != (FQ_PTR_W + 1)'(FQ_DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_pc_o    = pc_mem_q[rd_ptr_q];
  assign out_inst_o  = inst_mem_q[rd_ptr_q];

  // flush wins over both sides
  assign push = push_i && ready_o && !flush_i;
  assign pop  = out_valid_o && out_ready_i && !flush_i;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      pc_mem_q[wr_ptr_q]   <= push_pc_i;
      inst_mem_q[wr_ptr_q] <= push_inst_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the count
      if (push && !pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (pop && !push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         redirect_valid_i,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic [fetch_pkg::ADDR_W-1:0] out_pc_o,
  output logic [fetch_pkg::XLEN-1:0]   out_inst_o,
  output logic                         mem_arvalid_o,
  output logic [fetch_pkg::ADDR_W-1:0] mem_araddr_o,
  input  logic                         mem_arready_i,
  input  logic                         mem_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]   mem_rdata_i
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] fetch_pc;
  logic [XLEN-1:0]   fetch_inst;
  logic              fetched;
  logic              fq_ready;

  pc_gen u_pc_gen (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .advance_i        (fetched),
    .pc_o             (fetch_pc)
  );

  // hit_valid_o is already folded into fetched_o
  l1i_cache u_l1i_cache (
    .clk           (clk),
    .rst           (rst),
    .pc_i          (fetch_pc),
    .flush_i       (redirect_valid_i),
    .hit_valid_o   (),
    .inst_o        (fetch_inst),
    .take_i        (fq_ready),
    .fetched_o     (fetched),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arready_i (mem_arready_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  fetch_queue u_fetch_queue (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (redirect_valid_i),
    .push_i      (fetched),
    .push_pc_i   (fetch_pc),
    .push_inst_i (fetch_inst),
    .ready_o     (fq_ready),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_pc_o    (out_pc_o),
    .out_inst_o  (out_inst_o)
  );

endmodule

`default_nettype wire

//--- test/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int TIMEOUT = 2000;

  logic              clk = 1'b0;
  logic              rst;
  logic              redirect_valid_i;
  logic [ADDR_W-1:0] redirect_pc_i;
  logic              out_valid_o;
  logic              out_ready_i;
  logic [ADDR_W-1:0] out_pc_o;
  logic [XLEN-1:0]   out_inst_o;
  logic              mem_arvalid_o;
  logic [ADDR_W-1:0] mem_araddr_o;
  logic              mem_arready_i;
  logic              mem_rvalid_i;
  logic [XLEN-1:0]   mem_rdata_i;

  // memory model state
  logic              m_busy;
  logic [ADDR_W-1:0] m_addr;
  logic              m_beat;
  int unsigned       m_gap;
  int unsigned       ar_wait;
  int unsigned       ar_target;
  logic              first_req_seen;
  logic              filled_38;

  // reference pc and phase flags
  logic [ADDR_W-1:0] exp_pc;
  logic              hit_window = 1'b0;
  logic              expect_refetch = 1'b0;

  fetch_top u_fetch_top (.*);

  always #2 clk = ~clk;

  function automatic logic [XLEN-1:0] mem_word(input logic [ADDR_W-1:0] a);
    if (a == 32'h40)
      return FENCE_I_INST;
    return a + 32'h1357_0000;
  endfunction

  task automatic end_with_failure();
    $display("TEST FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end_with_failure();
  endtask

  task automatic report_problem(input string what);
    $display("%s at time %0t", what, $time);
    end_with_failure();
  endtask

  // random back-pressure until pc is handed over, optionally stalling after it
  task automatic run_until_xfer(input logic [ADDR_W-1:0] pc, input logic freeze);
    for (int i = 0; i < TIMEOUT; i++)
    begin
      @(posedge clk);
      if (out_valid_o && out_ready_i && out_pc_o == pc)
      begin
        if (freeze)
          out_ready_i <= 1'b0;
        return;
      end
      out_ready_i <= ($urandom_range(0, 3) != 0);
    end
    report_problem($sformatf("no transfer of pc %h before the timeout", pc));
  endtask

  task automatic wait_fill_38();
    for (int i = 0; i < TIMEOUT; i++)
    begin
      @(posedge clk);
      if (filled_38)
        return;
    end
    report_problem("line 0x38 was never refilled");
  endtask

  task automatic wait_request(input logic [ADDR_W-1:0] addr);
    for (int i = 0; i < TIMEOUT; i++)
    begin
      @(posedge clk);
      if (mem_arvalid_o && mem_arready_i && mem_araddr_o == addr)
        return;
      out_ready_i <= ($urandom_range(0, 3) != 0);
    end
    report_problem($sformatf("no bus request for address %h after the fence", addr));
  endtask

  task automatic redirect_to(input logic [ADDR_W-1:0] target);
    redirect_valid_i <= 1'b1;
    redirect_pc_i    <= target;
    out_ready_i      <= 1'b0;
    @(posedge clk);
    redirect_valid_i <= 1'b0;
  endtask

  // read memory, random arready wait and random gaps between beats
  always @(posedge clk)
  begin
    if (rst)
    begin
      mem_arready_i  <= 1'b0;
      mem_rvalid_i   <= 1'b0;
      m_busy         <= 1'b0;
      ar_wait        <= 0;
      ar_target      <= $urandom_range(0, 3);
      first_req_seen <= 1'b0;
      filled_38      <= 1'b0;
    end
    else if (!m_busy)
    begin
      if (mem_arvalid_o && mem_arready_i)
      begin
        m_busy         <= 1'b1;
        m_addr         <= mem_araddr_o;
        m_beat         <= 1'b0;
        m_gap          <= $urandom_range(0, 2);
        mem_arready_i  <= 1'b0;
        ar_wait        <= 0;
        ar_target      <= $urandom_range(0, 3);
        first_req_seen <= 1'b1;
      end
      else if (mem_arvalid_o && ar_wait >= ar_target)
        mem_arready_i <= 1'b1;
      else if (mem_arvalid_o)
        ar_wait <= ar_wait + 1;
    end
    else if (mem_rvalid_i)
    begin
      mem_rvalid_i <= 1'b0;
      m_gap        <= $urandom_range(0, 2);
      m_beat       <= 1'b1;
      if (m_beat)
        m_busy <= 1'b0;
      if (m_beat && m_addr == 32'h38)
        filled_38 <= 1'b1;
    end
    else if (m_gap == 0)
    begin
      mem_rvalid_i <= 1'b1;
      mem_rdata_i  <= mem_word(m_addr + (m_beat ? 32'd4 : 32'd0));
    end
    else
      m_gap <= m_gap - 1;
  end

  // next pc expected downstream
  always @(posedge clk)
  begin
    if (rst)
      exp_pc <= RESET_PC;
    else if (redirect_valid_i)
      exp_pc <= redirect_pc_i;
    else if (out_valid_o && out_ready_i)
      exp_pc <= exp_pc + 32'd4;
  end

  a_out_pc: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i) |-> (out_pc_o == exp_pc))
    else report_mismatch("out_pc_o", $sampled(exp_pc), $sampled(out_pc_o));

  a_out_inst: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i) |-> (out_inst_o == mem_word(out_pc_o)))
    else report_mismatch("out_inst_o", mem_word($sampled(out_pc_o)), $sampled(out_inst_o));

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
    !first_req_seen |-> !out_valid_o)
    else report_mismatch("out_valid_o", 32'd0, 32'd1);

  a_first_addr: assert property (@(posedge clk) disable iff (rst)
    (mem_arvalid_o && !first_req_seen) |-> (mem_araddr_o == RESET_PC))
    else report_mismatch("mem_araddr_o", RESET_PC, $sampled(mem_araddr_o));

  a_line_aligned: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o |-> (mem_araddr_o[2:0] == 3'b000))
    else report_mismatch("mem_araddr_o", {$sampled(mem_araddr_o[31:3]), 3'b000},
                         $sampled(mem_araddr_o));

  a_one_refill: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o |-> !m_busy)
    else report_mismatch("mem_arvalid_o", 32'd0, 32'd1);

  a_lines_hit: assert property (@(posedge clk) disable iff (rst)
    hit_window |-> !mem_arvalid_o)
    else report_mismatch("mem_arvalid_o", 32'd0, 32'd1);

  a_fence_refetch: assert property (@(posedge clk) disable iff (rst)
    expect_refetch |-> !out_valid_o)
    else report_mismatch("out_valid_o", 32'd0, 32'd1);

  initial
  begin
    void'($urandom(32'hc0dd));
    rst              = 1'b1;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    out_ready_i      = 1'b0;
    mem_arready_i    = 1'b0;
    mem_rvalid_i     = 1'b0;
    mem_rdata_i      = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // first pass stalls with 0x2c..0x38 queued so pc never passes 0x3c
    run_until_xfer(32'h28, 1'b1);
    wait_fill_38();
    redirect_to(32'h0);
    // second pass, every line below the fence is resident
    hit_window = 1'b1;
    run_until_xfer(32'h2c, 1'b0);
    hit_window = 1'b0;
    // stall right behind the fence so pc stays below set 3
    run_until_xfer(32'h40, 1'b1);
    redirect_to(32'h0);
    expect_refetch = 1'b1;
    wait_request(32'h0);
    expect_refetch = 1'b0;
    // line 0x38 was never replaced, so only the fence can make it miss
    wait_request(32'h38);
    run_until_xfer(32'h7c, 1'b0);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
source/fetch_pkg.sv
source/pc_gen.sv
source/l1i_cache.sv
source/fetch_queue.sv
source/fetch_top.sv
test/tb_fetch_top.sv

//--- Bender.yml
package:
  name: l1i_fetch

sources:
  - source/fetch_pkg.sv
  - source/pc_gen.sv
  - source/l1i_cache.sv
  - source/fetch_queue.sv
  - source/fetch_top.sv
  - target: test
    files:
      - test/tb_fetch_top.sv
